// ==== verilog.f ====
+incdir+.
rob_pkg.sv
rob_pointers.sv
rob_entries.sv
rob_commit_fsm.sv
reorder_buffer.sv
tb_reorder_buffer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_reorder_buffer
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP)

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell grep -v '^+' $(FILELIST)) rob_consts.svh $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_reorder_buffer.sv ====
/*
 * Reorder buffer testbench
 * Checks in-order commit, back-pressure, branch redirects and the LSU handshake
 * against a reference queue of accepted enqueues
 */

`default_nettype none

`include "rob_consts.svh"

module tb_reorder_buffer;

    import rob_pkg::*;

    typedef struct packed {
        logic [`ROB_IDX_WIDTH-1:0]  tag;
        logic [`ROB_REG_WIDTH-1:0]  rdest;
        logic [`ROB_DATA_WIDTH-1:0] data;
    } ref_entry_t;

    // Roughly 32 operations with generous room for each of them
    localparam int NUM_OPS        = 32;
    localparam int WATCHDOG_TIME  = NUM_OPS * 60 * 100;
    localparam int WAIT_LIMIT     = 200;

    logic                                 clk;
    logic                                 n_rst;
    logic                                 i_enq_en;
    enq_req_t                             i_enq;
    logic                                 o_stall;
    logic [`ROB_IDX_WIDTH-1:0]            o_enq_tag;
    cdb_bcast_t [`ROB_CDB_COUNT-1:0]      i_cdb;
    retire_t                              o_retire;
    logic                                 o_redirect;
    logic [`ROB_ADDR_WIDTH-1:0]           o_redirect_addr;
    logic                                 o_lsu_req;
    logic [`ROB_IDX_WIDTH-1:0]            o_lsu_tag;
    logic                                 i_lsu_ack;
    logic                                 i_lsu_misspec;

    ref_entry_t                           ref_q[$];
    ref_entry_t                           retired_ref;
    logic [`ROB_DATA_WIDTH-1:0]           tag_data [`ROB_DEPTH];
    logic [`ROB_IDX_WIDTH-1:0]            exp_tag;
    logic [`ROB_ADDR_WIDTH-1:0]           exp_redirect_addr;
    logic                                 redirect_armed;
    int                                   redirect_count;
    logic [15:0]                          lfsr_q;

    reorder_buffer reorder_buffer_i (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_enq_en        (i_enq_en),
        .i_enq           (i_enq),
        .o_stall         (o_stall),
        .o_enq_tag       (o_enq_tag),
        .i_cdb           (i_cdb),
        .o_retire        (o_retire),
        .o_redirect      (o_redirect),
        .o_redirect_addr (o_redirect_addr),
        .o_lsu_req       (o_lsu_req),
        .o_lsu_tag       (o_lsu_tag),
        .i_lsu_ack       (i_lsu_ack),
        .i_lsu_misspec   (i_lsu_misspec)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    initial begin
        #(WATCHDOG_TIME);
        fail_run("Watchdog expired before the tests finished");
    end

    // Galois LFSR, one step per bit taken
    function automatic logic lfsr_bit();
        logic lsb;
        lsb    = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (lsb) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] val;
        for (int i = 0; i < 32; i++) begin
            val[i] = lfsr_bit();
        end
        return val;
    endfunction

    function automatic cdb_bcast_t make_bcast(input logic [`ROB_IDX_WIDTH-1:0] tag,
                                              input logic redirect,
                                              input logic [`ROB_ADDR_WIDTH-1:0] addr);
        return '{en: 1'b1, redirect: redirect, tag: tag, data: tag_data[tag], addr: addr};
    endfunction

    // Inputs change a short time after each rising edge
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic enqueue(input rob_op_e op, input logic [31:0] pc, output logic accepted);
        logic [`ROB_REG_WIDTH-1:0]  rdest;
        logic [`ROB_DATA_WIDTH-1:0] data;
        for (int i = 0; i < `ROB_REG_WIDTH; i++) begin
            rdest[i] = lfsr_bit();
        end
        i_enq_en = 1'b1;
        i_enq    = '{op: op, pc: pc, rdest: rdest};
        accepted = !o_stall;
        if (accepted) begin
            assert (o_enq_tag == exp_tag) else fail_run($sformatf(
                "MISMATCH o_enq_tag: got %h expected %h", o_enq_tag, exp_tag));
            data              = rand_word();
            tag_data[exp_tag] = data;
            ref_q.push_back('{tag: exp_tag, rdest: rdest, data: data});
            exp_tag = exp_tag + 4'd1;
        end
        step();
        i_enq_en = 1'b0;
    endtask

    task automatic broadcast(input cdb_bcast_t b0, input cdb_bcast_t b1);
        i_cdb[0] = b0;
        i_cdb[1] = b1;
        step();
        i_cdb = '0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (ref_q.size() != 0) begin
            step();
            n++;
            assert (n < WAIT_LIMIT) else fail_run("Outstanding entries never retired");
        end
    endtask

    task automatic wait_redirect(input int count);
        int n;
        n = 0;
        while (redirect_count < count) begin
            step();
            n++;
            assert (n < WAIT_LIMIT) else fail_run("Expected redirect never arrived");
        end
        step();
    endtask

    task automatic wait_lsu_req();
        int n;
        n = 0;
        while (!o_lsu_req) begin
            step();
            n++;
            assert (n < WAIT_LIMIT) else fail_run("LSU request never raised");
        end
    endtask

    // Outputs are sampled on the falling edge where they are settled
    always @(negedge clk) begin
        if (n_rst) begin
            if (o_retire.en) begin
                assert (ref_q.size() != 0) else fail_run("Retire pulse with no outstanding entry");
                assert (!i_lsu_ack) else fail_run("Retire while LSU ack still high");
                retired_ref = ref_q.pop_front();
                assert (o_retire.tag == retired_ref.tag) else fail_run($sformatf(
                    "MISMATCH o_retire.tag: got %h expected %h", o_retire.tag, retired_ref.tag));
                assert (o_retire.rdest == retired_ref.rdest) else fail_run($sformatf(
                    "MISMATCH o_retire.rdest: got %h expected %h",
                    o_retire.rdest, retired_ref.rdest));
                assert (o_retire.data == retired_ref.data) else fail_run($sformatf(
                    "MISMATCH o_retire.data: got %h expected %h",
                    o_retire.data, retired_ref.data));
            end
            if (o_redirect) begin
                assert (redirect_armed) else fail_run("Redirect without a redirecting entry");
                assert (o_redirect_addr == exp_redirect_addr) else fail_run($sformatf(
                    "MISMATCH o_redirect_addr: got %h expected %h",
                    o_redirect_addr, exp_redirect_addr));
                assert (o_stall) else fail_run("Stall low during a flush");
                // Younger entries are squashed and tags restart at zero
                ref_q.delete();
                exp_tag        = '0;
                redirect_armed = 1'b0;
                redirect_count++;
            end
            if (o_lsu_req) begin
                assert (ref_q.size() != 0) else fail_run("LSU request with no outstanding entry");
                assert (o_lsu_tag == ref_q[0].tag) else fail_run($sformatf(
                    "MISMATCH o_lsu_tag: got %h expected %h", o_lsu_tag, ref_q[0].tag));
            end
        end
    end

    initial begin
        logic                       ok;
        logic [`ROB_ADDR_WIDTH-1:0] target;
        logic [`ROB_ADDR_WIDTH-1:0] st_pc;
        logic [`ROB_IDX_WIDTH-1:0]  t;

        n_rst             = 1'b0;
        i_enq_en          = 1'b0;
        i_enq             = '0;
        i_cdb             = '0;
        i_lsu_ack         = 1'b0;
        i_lsu_misspec     = 1'b0;
        lfsr_q            = 16'd62;
        exp_tag           = '0;
        exp_redirect_addr = '0;
        redirect_armed    = 1'b0;
        redirect_count    = 0;
        repeat (2) @(posedge clk);
        #10;
        n_rst = 1'b1;
        step();

        assert (!o_retire.en && !o_redirect && !o_lsu_req && !o_stall)
            else fail_run("Outputs not idle after reset");

        // Eight INT ops completing out of order, some pairs on both buses
        for (int i = 0; i < 8; i++) begin
            enqueue(ROB_OP_INT, rand_word(), ok);
        end
        broadcast(make_bcast(4'd5, 1'b0, rand_word()), make_bcast(4'd2, 1'b0, rand_word()));
        broadcast(make_bcast(4'd7, 1'b0, rand_word()), '0);
        broadcast(make_bcast(4'd0, 1'b0, rand_word()), make_bcast(4'd3, 1'b0, rand_word()));
        broadcast(make_bcast(4'd6, 1'b0, rand_word()), '0);
        broadcast(make_bcast(4'd1, 1'b0, rand_word()), make_bcast(4'd4, 1'b0, rand_word()));
        wait_drain();

        // Fill all sixteen entries, then one more attempt must be refused
        for (int i = 0; i < 16; i++) begin
            enqueue(ROB_OP_INT, rand_word(), ok);
            assert (ok) else fail_run("Enqueue refused before the buffer was full");
        end
        assert (o_stall) else fail_run("Stall low with a full buffer");
        enqueue(ROB_OP_INT, rand_word(), ok);
        assert (!ok) else fail_run("Enqueue accepted while full");
        assert (o_enq_tag == exp_tag) else fail_run($sformatf(
            "MISMATCH o_enq_tag: got %h expected %h", o_enq_tag, exp_tag));
        for (int i = 15; i > 0; i -= 2) begin
            broadcast(make_bcast(4'(8 + i), 1'b0, rand_word()),
                      make_bcast(4'(7 + i), 1'b0, rand_word()));
        end
        wait_drain();

        // Branch in the middle redirects and squashes the younger entries
        target = rand_word();
        enqueue(ROB_OP_INT, rand_word(), ok);
        enqueue(ROB_OP_BR, rand_word(), ok);
        enqueue(ROB_OP_INT, rand_word(), ok);
        enqueue(ROB_OP_INT, rand_word(), ok);
        exp_redirect_addr = target;
        redirect_armed    = 1'b1;
        broadcast(make_bcast(ref_q[0].tag, 1'b0, rand_word()),
                  make_bcast(ref_q[1].tag, 1'b1, target));
        broadcast(make_bcast(ref_q[2].tag, 1'b0, rand_word()),
                  make_bcast(ref_q[3].tag, 1'b0, rand_word()));
        wait_redirect(1);
        enqueue(ROB_OP_INT, rand_word(), ok);
        assert (ok) else fail_run("Enqueue refused after the flush");
        broadcast(make_bcast(4'd0, 1'b0, rand_word()), '0);
        wait_drain();

        // Load released over the full handshake
        enqueue(ROB_OP_LD, rand_word(), ok);
        t = ref_q[0].tag;
        broadcast(make_bcast(t, 1'b0, rand_word()), '0);
        wait_lsu_req();
        repeat (3) begin
            step();
            assert (o_lsu_req) else fail_run("LSU request dropped before ack");
        end
        i_lsu_ack = 1'b1;
        step();
        assert (!o_lsu_req) else fail_run("LSU request still high after ack");
        // Ack stays high long enough for an early retire pulse to show up
        repeat (2) step();
        assert (ref_q.size() == 1) else fail_run("Load retired before ack returned low");
        i_lsu_ack = 1'b0;
        wait_drain();

        // Misspeculated store redirects to its own pc
        st_pc = rand_word();
        enqueue(ROB_OP_ST, st_pc, ok);
        t = ref_q[0].tag;
        broadcast(make_bcast(t, 1'b0, rand_word()), '0);
        wait_lsu_req();
        exp_redirect_addr = st_pc;
        redirect_armed    = 1'b1;
        i_lsu_ack         = 1'b1;
        i_lsu_misspec     = 1'b1;
        step();
        i_lsu_ack     = 1'b0;
        i_lsu_misspec = 1'b0;
        wait_redirect(2);

        // The store flush also restarts tags at zero and releases dispatch
        assert (o_enq_tag == exp_tag) else fail_run($sformatf(
            "MISMATCH o_enq_tag: got %h expected %h", o_enq_tag, exp_tag));
        assert (!o_stall) else fail_run("Stall still high after the store flush");

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== reorder_buffer.sv ====
/*
 * Reorder buffer top level
 * In-order commit of out-of-order results for a 16-entry window
 */

`default_nettype none

`include "rob_consts.svh"

module reorder_buffer (
    input  wire logic                                    clk,
    input  wire logic                                    n_rst,

    // Dispatch side
    input  wire logic                                    i_enq_en,
    input  wire rob_pkg::enq_req_t                       i_enq,
    output logic                                         o_stall,
    output logic [`ROB_IDX_WIDTH-1:0]                    o_enq_tag,

    // Result buses
    input  wire rob_pkg::cdb_bcast_t [`ROB_CDB_COUNT-1:0] i_cdb,

    // Register map and fetch
    output rob_pkg::retire_t                             o_retire,
    output logic                                         o_redirect,
    output logic [`ROB_ADDR_WIDTH-1:0]                   o_redirect_addr,

    // LSU release handshake
    output logic                                         o_lsu_req,
    output logic [`ROB_IDX_WIDTH-1:0]                    o_lsu_tag,
    input  wire logic                                    i_lsu_ack,
    input  wire logic                                    i_lsu_misspec
);

    import rob_pkg::*;

    logic [`ROB_IDX_WIDTH-1:0] head_idx;
    logic [`ROB_IDX_WIDTH-1:0] tail_idx;
    logic                      empty;
    logic                      enq_accept;
    logic                      head_advance;
    logic                      flush;
    head_entry_t               head;

    // The tail index is the tag the next enqueue will receive
    assign o_enq_tag = tail_idx;

    rob_pointers rob_pointers_i (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_enq_en       (i_enq_en),
        .i_head_advance (head_advance),
        .i_flush        (flush),
        .o_head_idx     (head_idx),
        .o_tail_idx     (tail_idx),
        .o_empty        (empty),
        .o_stall        (o_stall),
        .o_enq_accept   (enq_accept)
    );

    rob_entries rob_entries_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_enq_accept (enq_accept),
        .i_tail_idx   (tail_idx),
        .i_enq        (i_enq),
        .i_cdb        (i_cdb),
        .i_head_idx   (head_idx),
        .i_flush      (flush),
        .o_head       (head)
    );

    rob_commit_fsm rob_commit_fsm_i (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_head          (head),
        .i_head_idx      (head_idx),
        .i_empty         (empty),
        .i_lsu_ack       (i_lsu_ack),
        .i_lsu_misspec   (i_lsu_misspec),
        .o_head_advance  (head_advance),
        .o_flush         (flush),
        .o_retire        (o_retire),
        .o_redirect      (o_redirect),
        .o_redirect_addr (o_redirect_addr),
        .o_lsu_req       (o_lsu_req),
        .o_lsu_tag       (o_lsu_tag)
    );

endmodule

`default_nettype wire

// ==== rob_commit_fsm.sv ====
/*
 * Reorder buffer commit FSM
 * Retires the head in order, releases loads and stores to the LSU
 * over a four-phase handshake and issues redirects with a flush
 */

`default_nettype none

`include "rob_consts.svh"

module rob_commit_fsm (
    input  wire logic                        clk,
    input  wire logic                        n_rst,

    input  wire rob_pkg::head_entry_t        i_head,
    input  wire logic [`ROB_IDX_WIDTH-1:0]   i_head_idx,
    input  wire logic                        i_empty,

    input  wire logic                        i_lsu_ack,
    input  wire logic                        i_lsu_misspec,

    output logic                             o_head_advance,
    output logic                             o_flush,
    output rob_pkg::retire_t                 o_retire,
    output logic                             o_redirect,
    output logic [`ROB_ADDR_WIDTH-1:0]       o_redirect_addr,
    output logic                             o_lsu_req,
    output logic [`ROB_IDX_WIDTH-1:0]        o_lsu_tag
);

    import rob_pkg::*;

    commit_state_e              state_q;
    commit_state_e              state_next;
    logic                       head_is_mem;
    logic                       retire_fire;
    logic                       misspec_q;

    logic                       retire_en_q;
    logic [`ROB_REG_WIDTH-1:0]  retire_rdest_q;
    logic [`ROB_IDX_WIDTH-1:0]  retire_tag_q;
    logic [`ROB_DATA_WIDTH-1:0] retire_data_q;
    logic [`ROB_ADDR_WIDTH-1:0] redirect_addr_q;

    assign head_is_mem = (i_head.op == ROB_OP_LD) || (i_head.op == ROB_OP_ST);

    always_comb begin
        state_next  = state_q;
        retire_fire = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (!i_empty && i_head.rdy) begin
                    if (head_is_mem) begin
                        state_next = ST_LSU_REQ;
                    end else begin
                        retire_fire = 1'b1;
                        if (i_head.redirect) begin
                            state_next = ST_FLUSH;
                        end
                    end
                end
            end
            // Request stays up until the LSU acknowledges
            ST_LSU_REQ: begin
                if (i_lsu_ack) begin
                    state_next = ST_LSU_DROP;
                end
            end
            // Ack going low closes the handshake and the entry retires
            ST_LSU_DROP: begin
                if (!i_lsu_ack) begin
                    retire_fire = 1'b1;
                    state_next  = (i_head.redirect || misspec_q) ? ST_FLUSH : ST_IDLE;
                end
            end
            ST_FLUSH: begin
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_next;
        end
    end

    // Misspeculation is only valid alongside the first cycle of ack
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            misspec_q <= 1'b0;
        end else if (state_q == ST_LSU_REQ && i_lsu_ack) begin
            misspec_q <= i_lsu_misspec;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            retire_en_q <= 1'b0;
        end else begin
            retire_en_q <= retire_fire;
        end
    end

    // Branches jump to their resolved target, anything else restarts at its own pc
    always_ff @(posedge clk) begin
        if (retire_fire) begin
            retire_rdest_q  <= i_head.rdest;
            retire_tag_q    <= i_head_idx;
            retire_data_q   <= i_head.data;
            redirect_addr_q <= (i_head.op == ROB_OP_BR) ? i_head.addr : i_head.pc;
        end
    end

    assign o_retire = '{
        en:    retire_en_q,
        rdest: retire_rdest_q,
        tag:   retire_tag_q,
        data:  retire_data_q
    };

    assign o_head_advance  = retire_fire;
    assign o_flush         = (state_q == ST_FLUSH);
    assign o_redirect      = (state_q == ST_FLUSH);
    assign o_redirect_addr = redirect_addr_q;

    // Head does not move during the handshake, so its index serves as the tag
    assign o_lsu_req = (state_q == ST_LSU_REQ);
    assign o_lsu_tag = i_head_idx;

endmodule

`default_nettype wire

// ==== rob_entries.sv ====
/*
 * Reorder buffer entry storage
 * Fills entries at the tail, takes result-bus writebacks by tag
 * and shows the entry at the head to the commit logic
 */

`default_nettype none

`include "rob_consts.svh"

module rob_entries (
    input  wire logic                                    clk,
    input  wire logic                                    n_rst,

    input  wire logic                                    i_enq_accept,
    input  wire logic [`ROB_IDX_WIDTH-1:0]               i_tail_idx,
    input  wire rob_pkg::enq_req_t                       i_enq,

    input  wire rob_pkg::cdb_bcast_t [`ROB_CDB_COUNT-1:0] i_cdb,

    input  wire logic [`ROB_IDX_WIDTH-1:0]               i_head_idx,
    input  wire logic                                    i_flush,

    output rob_pkg::head_entry_t                         o_head
);

    import rob_pkg::*;

    localparam logic [`ROB_DEPTH-1:0] ONE_HOT_0 = {{(`ROB_DEPTH-1){1'b0}}, 1'b1};

    // Control bits per entry
    logic [`ROB_DEPTH-1:0]      rdy_q;
    logic [`ROB_DEPTH-1:0]      redirect_q;

    // Payload per entry
    rob_op_e                    op_q    [`ROB_DEPTH];
    logic [`ROB_ADDR_WIDTH-1:0] pc_q    [`ROB_DEPTH];
    logic [`ROB_ADDR_WIDTH-1:0] addr_q  [`ROB_DEPTH];
    logic [`ROB_DATA_WIDTH-1:0] data_q  [`ROB_DEPTH];
    logic [`ROB_REG_WIDTH-1:0]  rdest_q [`ROB_DEPTH];

    logic [`ROB_DEPTH-1:0]      enq_sel;
    logic [`ROB_DEPTH-1:0]      cdb_sel [`ROB_CDB_COUNT];
    logic [`ROB_DEPTH-1:0]      cdb_hit;
    logic [`ROB_DEPTH-1:0]      cdb_redirect;
    logic [`ROB_ADDR_WIDTH-1:0] addr_next [`ROB_DEPTH];
    logic [`ROB_DATA_WIDTH-1:0] data_next [`ROB_DEPTH];

    assign enq_sel = {(`ROB_DEPTH){i_enq_accept}} & (ONE_HOT_0 << i_tail_idx);

    // Decode each bus tag into a one-hot entry select
    always_comb begin
        for (int c = 0; c < `ROB_CDB_COUNT; c++) begin
            cdb_sel[c] = {(`ROB_DEPTH){i_cdb[c].en}} & (ONE_HOT_0 << i_cdb[c].tag);
        end
    end

    // Merge the buses per entry, the higher bus index is applied last and wins
    always_comb begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            cdb_hit[i]      = 1'b0;
            cdb_redirect[i] = 1'b0;
            addr_next[i]    = addr_q[i];
            data_next[i]    = data_q[i];
            for (int c = 0; c < `ROB_CDB_COUNT; c++) begin
                if (cdb_sel[c][i]) begin
                    cdb_hit[i]      = 1'b1;
                    cdb_redirect[i] = cdb_redirect[i] | i_cdb[c].redirect;
                    addr_next[i]    = i_cdb[c].addr;
                    data_next[i]    = i_cdb[c].data;
                end
            end
        end
    end

    // A fresh entry starts not ready; a flush drops every pending result
    always_ff @(posedge clk) begin
        if (!n_rst || i_flush) begin
            rdy_q <= '0;
        end else begin
            rdy_q <= (rdy_q | cdb_hit) & ~enq_sel;
        end
    end

    always_ff @(posedge clk) begin
        redirect_q <= (redirect_q | cdb_redirect) & ~enq_sel;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            if (enq_sel[i]) begin
                op_q[i]    <= i_enq.op;
                pc_q[i]    <= i_enq.pc;
                rdest_q[i] <= i_enq.rdest;
            end
            addr_q[i] <= addr_next[i];
            data_q[i] <= data_next[i];
        end
    end

    // Head view straight from the registers
    assign o_head = '{
        rdy:      rdy_q[i_head_idx],
        redirect: redirect_q[i_head_idx],
        op:       op_q[i_head_idx],
        pc:       pc_q[i_head_idx],
        addr:     addr_q[i_head_idx],
        data:     data_q[i_head_idx],
        rdest:    rdest_q[i_head_idx]
    };

endmodule

`default_nettype wire

// ==== rob_pointers.sv ====
/*
 * Reorder buffer head and tail pointers
 * Tracks occupancy with a wrap bit and decides whether an enqueue is taken
 */

`default_nettype none

`include "rob_consts.svh"

module rob_pointers (
    input  wire logic                      clk,
    input  wire logic                      n_rst,

    input  wire logic                      i_enq_en,
    input  wire logic                      i_head_advance,
    input  wire logic                      i_flush,

    output logic [`ROB_IDX_WIDTH-1:0]      o_head_idx,
    output logic [`ROB_IDX_WIDTH-1:0]      o_tail_idx,
    output logic                           o_empty,
    output logic                           o_stall,
    output logic                           o_enq_accept
);

    logic [`ROB_PTR_WIDTH-1:0] head_q;
    logic [`ROB_PTR_WIDTH-1:0] tail_q;
    logic [`ROB_PTR_WIDTH-1:0] head_next;
    logic [`ROB_PTR_WIDTH-1:0] tail_next;
    logic                      full_q;
    logic                      empty_q;

    // No new entries while the buffer is full or being flushed
    assign o_stall      = full_q | i_flush;
    assign o_enq_accept = i_enq_en & ~o_stall;

    // A flush returns both pointers to entry zero so tags restart at 0
    assign head_next = i_flush ? '0 : head_q + {{(`ROB_IDX_WIDTH){1'b0}}, i_head_advance};
    assign tail_next = i_flush ? '0 : tail_q + {{(`ROB_IDX_WIDTH){1'b0}}, o_enq_accept};

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= head_next;
            tail_q <= tail_next;
        end
    end

    // Full when the indices match but the wrap bits differ
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            full_q  <= 1'b0;
            empty_q <= 1'b1;
        end else begin
            full_q  <= ({~tail_next[`ROB_PTR_WIDTH-1], tail_next[`ROB_IDX_WIDTH-1:0]}
                        == head_next);
            empty_q <= (tail_next == head_next);
        end
    end

    assign o_head_idx = head_q[`ROB_IDX_WIDTH-1:0];
    assign o_tail_idx = tail_q[`ROB_IDX_WIDTH-1:0];
    assign o_empty    = empty_q;

endmodule

`default_nettype wire

// ==== rob_pkg.sv ====
/*
 * Reorder buffer types
 * Instruction classes, commit states and the records passed between blocks
 */

`default_nettype none

`include "rob_consts.svh"

package rob_pkg;

    typedef enum logic [1:0] {
        ROB_OP_INT = 2'b00,
        ROB_OP_BR  = 2'b01,
        ROB_OP_LD  = 2'b10,
        ROB_OP_ST  = 2'b11
    } rob_op_e;

    typedef enum logic [1:0] {
        ST_IDLE     = 2'b00,
        ST_LSU_REQ  = 2'b01,
        ST_LSU_DROP = 2'b10,
        ST_FLUSH    = 2'b11
    } commit_state_e;

    // New instruction handed over by dispatch
    typedef struct packed {
        rob_op_e                    op;
        logic [`ROB_ADDR_WIDTH-1:0] pc;
        logic [`ROB_REG_WIDTH-1:0]  rdest;
    } enq_req_t;

    // One broadcast on a result bus, addr is the branch target
    typedef struct packed {
        logic                       en;
        logic                       redirect;
        logic [`ROB_IDX_WIDTH-1:0]  tag;
        logic [`ROB_DATA_WIDTH-1:0] data;
        logic [`ROB_ADDR_WIDTH-1:0] addr;
    } cdb_bcast_t;

    typedef struct packed {
        logic                       rdy;
        logic                       redirect;
        rob_op_e                    op;
        logic [`ROB_ADDR_WIDTH-1:0] pc;
        logic [`ROB_ADDR_WIDTH-1:0] addr;
        logic [`ROB_DATA_WIDTH-1:0] data;
        logic [`ROB_REG_WIDTH-1:0]  rdest;
    } head_entry_t;

    // Committed result for the register map
    typedef struct packed {
        logic                       en;
        logic [`ROB_REG_WIDTH-1:0]  rdest;
        logic [`ROB_IDX_WIDTH-1:0]  tag;
        logic [`ROB_DATA_WIDTH-1:0] data;
    } retire_t;

endpackage

`default_nettype wire

// ==== rob_consts.svh ====
/*
 * Reorder buffer sizing constants
 * Depth, pointer and datapath widths shared by every block of the buffer
 */

`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// Number of entries and the index that selects one of them
`define ROB_DEPTH       16
`define ROB_IDX_WIDTH   4

// Head and tail carry one extra wrap bit to tell full from empty
`define ROB_PTR_WIDTH   5

`define ROB_DATA_WIDTH  32
`define ROB_ADDR_WIDTH  32
`define ROB_REG_WIDTH   5

// Result buses that can write back in the same cycle
`define ROB_CDB_COUNT   2

`endif
